//--- design/qpimem_macros.svh
`ifndef QPIMEM_MACROS_SVH
`define QPIMEM_MACROS_SVH

// Word address width, one word is 32 bits
`define QPIMEM_ADDR_WIDTH 22

// Cache geometry per port
`define QPIMEM_LINE_WORDS 4
`define QPIMEM_LINE_CT 32

// Only the 2-way LRU logic exists in the cache
`define QPIMEM_WAYS 2

// Derived address split {tag, set, offset}
`define QPIMEM_SETS (`QPIMEM_LINE_CT / `QPIMEM_WAYS)
`define QPIMEM_OFFSET_BITS $clog2(`QPIMEM_LINE_WORDS)
`define QPIMEM_SET_BITS $clog2(`QPIMEM_SETS)
`define QPIMEM_TAG_BITS (`QPIMEM_ADDR_WIDTH - `QPIMEM_SET_BITS - `QPIMEM_OFFSET_BITS)

// Caches that share the one memory channel
`define QPIMEM_PORTS 2

`endif

//--- design/qpimem_pkg.sv
`include "qpimem_macros.svh"

package qpimem_pkg;

	// Word address seen as cache fields
	typedef struct packed {
		logic [`QPIMEM_TAG_BITS-1:0] tag;
		logic [`QPIMEM_SET_BITS-1:0] set;
		logic [`QPIMEM_OFFSET_BITS-1:0] offset;
	} word_fields_t;

	// Same word address, flat or split
	typedef union packed {
		logic [`QPIMEM_ADDR_WIDTH-1:0] word;
		word_fields_t f;
	} word_addr_t;

	// CPU side request of one port
	typedef struct packed {
		word_addr_t addr;
		// Byte enables, all zero means no write
		logic [3:0] wen;
		logic ren;
		logic [31:0] wdata;
	} cpu_req_t;

	// Cache toward the memory channel
	typedef struct packed {
		logic do_read;
		logic do_write;
		// Byte address, always line aligned at command start
		logic [`QPIMEM_ADDR_WIDTH+2-1:0] addr;
		logic [31:0] wdata;
	} mem_req_t;

	// Memory channel back toward a cache
	typedef struct packed {
		// One pulse per transferred word
		logic next_word;
		logic [31:0] rdata;
		// Controller free for a new command
		logic is_idle;
	} mem_rsp_t;

endpackage

//--- design/qpimem_cache.sv
`timescale 1ns/1ps
`include "qpimem_macros.svh"

module qpimem_cache
	import qpimem_pkg::*;
(
	input logic clk,
	input logic rst,
	input cpu_req_t cpu,
	output logic ready,
	output logic [31:0] rdata,
	output logic bus_req,
	output mem_req_t mem_req,
	input mem_rsp_t mem_rsp
);

	// Line address is the word address without the offset
	localparam int LINE_ADDR_BITS = `QPIMEM_ADDR_WIDTH - `QPIMEM_OFFSET_BITS;

	// Data, tag and flag storage
	logic [31:0] data_mem [`QPIMEM_WAYS][`QPIMEM_SETS][`QPIMEM_LINE_WORDS];
	logic [`QPIMEM_TAG_BITS-1:0] tag_mem [`QPIMEM_WAYS][`QPIMEM_SETS];
	logic [`QPIMEM_WAYS-1:0][`QPIMEM_SETS-1:0] valid_q;
	logic [`QPIMEM_WAYS-1:0][`QPIMEM_SETS-1:0] dirty_q;
	// Per set, index of the least recently used way
	logic [`QPIMEM_SETS-1:0] lru_q;

	// Current request decoded
	word_addr_t cur_addr;
	logic [`QPIMEM_TAG_BITS-1:0] cur_tag;
	logic [`QPIMEM_SET_BITS-1:0] cur_set;
	logic [`QPIMEM_OFFSET_BITS-1:0] cur_off;

	// Hit detection
	logic [`QPIMEM_WAYS-1:0] way_hit;
	logic hit;
	logic hit_way;
	logic cpu_write;
	logic cpu_access;

	// Miss handling
	logic need_refill;
	logic victim;
	logic victim_dirty;
	logic do_read_q;
	logic do_write_q;
	logic done_q;
	logic [`QPIMEM_OFFSET_BITS-1:0] cnt_q;
	logic [LINE_ADDR_BITS-1:0] line_q;
	logic [31:0] wdata_q;
	logic start;
	logic rd_beat;
	logic wr_beat;
	logic last_word;

	assign cur_addr = cpu.addr;
	assign cur_tag = cur_addr.f.tag;
	assign cur_set = cur_addr.f.set;
	assign cur_off = cur_addr.f.offset;

	assign cpu_write = (cpu.wen != 4'b0000);
	assign cpu_access = cpu.ren || cpu_write;

	// Tag compare on both ways, invalid lines never match
	always_comb begin
		way_hit = '0;
		for (int w = 0; w < `QPIMEM_WAYS; w++) begin
			way_hit[w] = valid_q[w][cur_set] && (tag_mem[w][cur_set] == cur_tag);
		end
	end

	assign hit = |way_hit;
	// Two ways only, so way 1 matching names the way
	assign hit_way = way_hit[1];

	// Ready is simply the hit
	assign ready = hit;

	// Victim is always the LRU way of the set
	assign need_refill = !hit && cpu_access;
	assign victim = lru_q[cur_set];
	assign victim_dirty = dirty_q[victim][cur_set];
	assign bus_req = need_refill;

	// New command only once the controller is idle
	// done_q leaves one free cycle after each command for the arbiter
	assign start = need_refill && !done_q && !do_read_q && !do_write_q && mem_rsp.is_idle;
	assign rd_beat = do_read_q && mem_rsp.next_word;
	assign wr_beat = do_write_q && mem_rsp.next_word;
	assign last_word = &cnt_q;

	// Control state, flags and sequencer
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q <= '0;
			do_read_q <= 1'b0;
			do_write_q <= 1'b0;
			done_q <= 1'b0;
			cnt_q <= '0;
		end else begin
			done_q <= 1'b0;

			// Hit, the other way becomes LRU
			if (hit && cpu_access) begin
				lru_q[cur_set] <= !hit_way;
			end
			if (hit && cpu_write) begin
				dirty_q[hit_way][cur_set] <= 1'b1;
			end

			if (start) begin
				// Dirty victim goes back first, the refill comes on a later round
				cnt_q <= '0;
				if (victim_dirty) begin
					do_write_q <= 1'b1;
				end else begin
					do_read_q <= 1'b1;
				end
			end else if (rd_beat || wr_beat) begin
				cnt_q <= cnt_q + 1'b1;
				if (last_word) begin
					// Strobe drops on the edge of the last pulse
					do_read_q <= 1'b0;
					do_write_q <= 1'b0;
					done_q <= 1'b1;
					if (do_write_q) begin
						dirty_q[victim][cur_set] <= 1'b0;
					end else begin
						valid_q[victim][cur_set] <= 1'b1;
						dirty_q[victim][cur_set] <= 1'b0;
					end
				end
			end
		end
	end

	// Storage and payload registers
	always_ff @(posedge clk) begin
		// Read data lands one clock after the hit
		if (hit && cpu.ren) begin
			rdata <= data_mem[hit_way][cur_set][cur_off];
		end

		// Byte merge on a write hit
		if (hit && cpu_write) begin
			for (int b = 0; b < 4; b++) begin
				if (cpu.wen[b]) begin
					data_mem[hit_way][cur_set][cur_off][8*b +: 8] <= cpu.wdata[8*b +: 8];
				end
			end
		end

		if (start) begin
			// Writeback goes to the victim's own line, refill to the request's line
			if (victim_dirty) begin
				line_q <= {tag_mem[victim][cur_set], cur_set};
			end else begin
				line_q <= cur_addr.word[`QPIMEM_ADDR_WIDTH-1:`QPIMEM_OFFSET_BITS];
			end
			wdata_q <= data_mem[victim][cur_set][0];
		end

		// Next writeback word ready for the next pulse
		if (wr_beat) begin
			wdata_q <= data_mem[victim][cur_set][cnt_q + 1'b1];
		end

		// Refill one word per pulse
		if (rd_beat) begin
			data_mem[victim][cur_set][cnt_q] <= mem_rsp.rdata;
			// Tag on the last word, the line hits from the next cycle
			if (last_word) begin
				tag_mem[victim][cur_set] <= cur_tag;
			end
		end
	end

	// Channel request, byte address from line and word counter
	always_comb begin
		mem_req.do_read = do_read_q;
		mem_req.do_write = do_write_q;
		mem_req.addr = {line_q, cnt_q, 2'b00};
		mem_req.wdata = wdata_q;
	end

endmodule

//--- design/qpimem_arbiter.sv
`timescale 1ns/1ps
`include "qpimem_macros.svh"

module qpimem_arbiter
	import qpimem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [`QPIMEM_PORTS-1:0] bus_req,
	input mem_req_t cache_req [`QPIMEM_PORTS],
	output mem_rsp_t cache_rsp [`QPIMEM_PORTS],
	output mem_req_t mem_req,
	input mem_rsp_t mem_rsp
);

	localparam int GRANT_BITS = $clog2(`QPIMEM_PORTS);

	// Owner of the channel
	logic [GRANT_BITS-1:0] grant_q;
	// Owner had a strobe up last cycle
	logic busy_q;

	logic owner_active;
	logic may_switch;
	logic found;
	logic [GRANT_BITS-1:0] next_grant;

	assign owner_active = cache_req[grant_q].do_read || cache_req[grant_q].do_write;

	// Only between commands
	// Owner idle, or its command ended last cycle
	assign may_switch = !owner_active && (!bus_req[grant_q] || busy_q);

	// Round robin, search starts after the current owner
	always_comb begin
		int cand;
		found = 1'b0;
		next_grant = grant_q;
		for (int i = 1; i < `QPIMEM_PORTS; i++) begin
			cand = (int'(grant_q) + i) % `QPIMEM_PORTS;
			if (!found && bus_req[cand]) begin
				found = 1'b1;
				next_grant = GRANT_BITS'(cand);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			grant_q <= '0;
			busy_q <= 1'b0;
		end else begin
			busy_q <= owner_active;
			// Owner keeps the grant if nobody else asks
			if (may_switch && found) begin
				grant_q <= next_grant;
			end
		end
	end

	// Outward request is the owner's alone
	assign mem_req = cache_req[grant_q];

	// Responses only to the owner
	// Others see no pulses and never idle, so they wait
	always_comb begin
		for (int p = 0; p < `QPIMEM_PORTS; p++) begin
			if (grant_q == GRANT_BITS'(p)) begin
				cache_rsp[p] = mem_rsp;
			end else begin
				cache_rsp[p].next_word = 1'b0;
				cache_rsp[p].rdata = '0;
				cache_rsp[p].is_idle = 1'b0;
			end
		end
	end

endmodule

//--- design/qpimem_subsys.sv
`timescale 1ns/1ps
`include "qpimem_macros.svh"

module qpimem_subsys
	import qpimem_pkg::*;
(
	input logic clk,
	input logic rst,
	// CPU ports, one cache each
	input cpu_req_t cpu [`QPIMEM_PORTS],
	output logic ready [`QPIMEM_PORTS],
	output logic [31:0] rdata [`QPIMEM_PORTS],
	// Shared channel to the QPI controller
	output mem_req_t mem_req,
	input mem_rsp_t mem_rsp
);

	// Cache to arbiter wiring
	logic [`QPIMEM_PORTS-1:0] bus_req;
	mem_req_t cache_req [`QPIMEM_PORTS];
	mem_rsp_t cache_rsp [`QPIMEM_PORTS];

	// One cache per CPU port
	for (genvar p = 0; p < `QPIMEM_PORTS; p++) begin : g_cache
		qpimem_cache cache_i (
			.clk (clk),
			.rst (rst),
			.cpu (cpu[p]),
			.ready (ready[p]),
			.rdata (rdata[p]),
			.bus_req (bus_req[p]),
			.mem_req (cache_req[p]),
			.mem_rsp (cache_rsp[p])
		);
	end

	// Single owner of the memory channel
	qpimem_arbiter arbiter_i (
		.clk (clk),
		.rst (rst),
		.bus_req (bus_req),
		.cache_req (cache_req),
		.cache_rsp (cache_rsp),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

endmodule

//--- sim/qpi_mem_model.sv
`timescale 1ns/1ps
`include "qpimem_macros.svh"

module qpi_mem_model
	import qpimem_pkg::*;
(
	input logic clk,
	input logic rst,
	input mem_req_t mem_req,
	output mem_rsp_t mem_rsp
);

	// Written words only, the rest reads as the fill pattern
	logic [31:0] mem [int];

	logic [31:0] rnd_q;
	logic busy_q;
	logic is_write_q;
	int beats_q;
	logic [1:0] wait_q;
	logic [`QPIMEM_ADDR_WIDTH-1:0] base_q;

	// Fill pattern mixes every address bit
	function automatic logic [31:0] fill_word(input logic [`QPIMEM_ADDR_WIDTH-1:0] a);
		logic [31:0] x;
		x = 32'(a) * 32'h9e3779b1;
		return x ^ (x >> 15) ^ 32'hc3a51e0f;
	endfunction

	function automatic logic [31:0] step_rand(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] read_word(input logic [`QPIMEM_ADDR_WIDTH-1:0] a);
		if (mem.exists(int'(a)))
			return mem[int'(a)];
		return fill_word(a);
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			mem_rsp.next_word <= 1'b0;
			mem_rsp.rdata <= '0;
			mem_rsp.is_idle <= 1'b1;
			busy_q <= 1'b0;
			is_write_q <= 1'b0;
			beats_q <= 0;
			wait_q <= '0;
			base_q <= '0;
			rnd_q <= 32'hbe96a503;
		end else begin
			rnd_q <= step_rand(rnd_q);
			mem_rsp.next_word <= 1'b0;
			// Write data is taken on the edge that ends the pulse
			if (mem_rsp.next_word && is_write_q)
				mem[int'(base_q) + beats_q] = mem_req.wdata;
			if (!busy_q) begin
				if (mem_req.do_read || mem_req.do_write) begin
					busy_q <= 1'b1;
					mem_rsp.is_idle <= 1'b0;
					base_q <= mem_req.addr[`QPIMEM_ADDR_WIDTH+1:2];
					is_write_q <= mem_req.do_write;
					beats_q <= 0;
					wait_q <= rnd_q[1:0];
				end
			end else if (beats_q == `QPIMEM_LINE_WORDS) begin
				// Line done, free again
				busy_q <= 1'b0;
				mem_rsp.is_idle <= 1'b1;
			end else if (mem_rsp.next_word) begin
				beats_q <= beats_q + 1;
				wait_q <= rnd_q[1:0];
			end else if (wait_q == 2'd0) begin
				mem_rsp.next_word <= 1'b1;
				mem_rsp.rdata <= read_word(base_q + `QPIMEM_ADDR_WIDTH'(beats_q));
			end else begin
				wait_q <= wait_q - 2'd1;
			end
		end
	end

endmodule

//--- sim/tb_qpimem.sv
`timescale 1ns/1ps
`include "qpimem_macros.svh"

module tb_qpimem
	import qpimem_pkg::*;
;

	// Requests per test: reset, miss and hit, byte enables, eviction, shared channel
	localparam int TOTAL_REQ = 2 + 2 + 80 + 9 + 2000;
	// Low byte address bits that must be zero when a command starts
	localparam logic [31:0] LINE_BYTE_MASK = ~32'(`QPIMEM_LINE_WORDS * 4 - 1);

	logic clk;
	logic rst;
	cpu_req_t cpu [`QPIMEM_PORTS];
	logic ready [`QPIMEM_PORTS];
	logic [31:0] rdata [`QPIMEM_PORTS];
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;

	// Expected memory contents, written words only
	logic [31:0] ref_mem [int];
	logic [31:0] rnd_state;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;
	int wb_count;
	logic prev_strobe;
	logic prev_idle;

	qpimem_subsys dut0 (
		.clk (clk),
		.rst (rst),
		.cpu (cpu),
		.ready (ready),
		.rdata (rdata),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	qpi_mem_model mem0 (
		.clk (clk),
		.rst (rst),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rnd_state = rnd_state ^ (rnd_state << 13);
		rnd_state = rnd_state ^ (rnd_state >> 17);
		rnd_state = rnd_state ^ (rnd_state << 5);
		return rnd_state;
	endfunction

	// Unwritten memory words hold a hash of the address
	function automatic logic [31:0] expected_fill(input logic [`QPIMEM_ADDR_WIDTH-1:0] a);
		logic [31:0] x;
		x = 32'(a) * 32'h9e3779b1;
		return x ^ (x >> 15) ^ 32'hc3a51e0f;
	endfunction

	function automatic logic [31:0] ref_word(input logic [`QPIMEM_ADDR_WIDTH-1:0] a);
		if (ref_mem.exists(int'(a)))
			return ref_mem[int'(a)];
		return expected_fill(a);
	endfunction

	// Port 1 owns tag bit 14, which is word address bit 20
	function automatic logic [`QPIMEM_ADDR_WIDTH-1:0] pick_addr(input int p, input int tags);
		logic [31:0] r;
		logic [15:0] tag;
		r = next_rand();
		tag = 16'((p << 14) + int'(r[31:8] % 24'(tags)));
		return {tag, r[5:2], r[1:0]};
	endfunction

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act == exp) else begin
			$display("MISMATCH t=%0t %s expected %08h got %08h", $time, name, exp, act);
			test_errors++;
		end
	endtask

	// Drive one request at a falling edge and hold it until ready
	task automatic access(input int p, input logic [`QPIMEM_ADDR_WIDTH-1:0] a,
			input logic [3:0] wen, input logic ren, input logic [31:0] wdata,
			output int waited);
		logic [31:0] exp;
		logic [31:0] merged;
		cpu[p].addr.word = a;
		cpu[p].wen = wen;
		cpu[p].ren = ren;
		cpu[p].wdata = wdata;
		waited = 0;
		#1;
		while (!ready[p]) begin
			@(negedge clk);
			#1;
			waited++;
		end
		exp = ref_word(a);
		merged = exp;
		for (int b = 0; b < 4; b++) begin
			if (wen[b])
				merged[8*b +: 8] = wdata[8*b +: 8];
		end
		if (wen != 4'b0000)
			ref_mem[int'(a)] = merged;
		@(posedge clk);
		@(negedge clk);
		if (ren)
			check_word($sformatf("rdata[%0d]", p), exp, rdata[p]);
		cpu[p].ren = 1'b0;
		cpu[p].wen = 4'b0000;
	endtask

	// Random mix of reads and byte writes on one port
	task automatic random_traffic(input int p, input int count, input int tags);
		logic [31:0] r;
		logic [3:0] wen;
		int waited;
		for (int i = 0; i < count; i++) begin
			r = next_rand();
			wen = (r[4:1] == 4'b0000) ? 4'b1111 : r[4:1];
			if (r[0])
				access(p, pick_addr(p, tags), 4'b0000, 1'b1, 32'h0, waited);
			else
				access(p, pick_addr(p, tags), wen, 1'b0, next_rand(), waited);
		end
	endtask

	task automatic finish_test(input string name);
		// Channel monitor of this edge counts first
		#1;
		$display("%s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILED", test_errors);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		errors += test_errors;
		test_errors = 0;
		@(negedge clk);
	endtask

	// Channel monitor, sampled on the falling edge where all is settled
	always @(negedge clk) begin
		if (!rst) begin
			assert (!(mem_req.do_read && mem_req.do_write)) else begin
				$display("Read and write strobes are high together at t=%0t", $time);
				test_errors++;
			end
			if ((mem_req.do_read || mem_req.do_write) && !prev_strobe) begin
				assert (prev_idle) else begin
					$display("A command started before the controller was idle at t=%0t", $time);
					test_errors++;
				end
				// A command opens on a whole line
				check_word("mem_req.addr", 32'(mem_req.addr) & LINE_BYTE_MASK,
					32'(mem_req.addr));
			end
			// Each writeback word must equal the latest CPU data
			if (mem_req.do_write && mem_rsp.next_word) begin
				check_word("mem_req.wdata", ref_word(mem_req.addr[`QPIMEM_ADDR_WIDTH+1:2]),
					mem_req.wdata);
				wb_count++;
			end
		end
		prev_strobe <= mem_req.do_read || mem_req.do_write;
		prev_idle <= mem_rsp.is_idle;
	end

	// Watchdog sized from the request count
	initial begin
		#(TOTAL_REQ * 200 * 4);
		$display("Watchdog expired, the run did not finish in time");
		$display("Test failures found");
		$finish;
	end

	initial begin
		logic [`QPIMEM_ADDR_WIDTH-1:0] a;
		logic [`QPIMEM_ADDR_WIDTH-1:0] evict [3];
		logic [31:0] first;
		int waited;
		int wb_before;
		clk = 1'b0;
		rst = 1'b1;
		rnd_state = 32'hbe96a503;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		wb_count = 0;
		prev_strobe = 1'b0;
		prev_idle = 1'b0;
		for (int p = 0; p < `QPIMEM_PORTS; p++)
			cpu[p] = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Empty caches miss on anything
		@(negedge clk);
		cpu[0].addr.word = pick_addr(0, 4);
		cpu[0].ren = 1'b1;
		cpu[1].addr.word = pick_addr(1, 4);
		cpu[1].ren = 1'b1;
		#1;
		assert (!ready[0] && !ready[1]) else begin
			$display("A cache reported ready right after reset");
			test_errors++;
		end
		assert (!mem_req.do_read && !mem_req.do_write) else begin
			$display("A memory strobe is high right after reset");
			test_errors++;
		end
		// Requests stay put until both misses are served
		while (!(ready[0] && ready[1])) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		cpu[0].ren = 1'b0;
		cpu[1].ren = 1'b0;
		finish_test("reset_state");

		// Miss, then a re-read that hits at once
		a = pick_addr(0, 4);
		access(0, a, 4'b0000, 1'b1, 32'h0, waited);
		first = rdata[0];
		access(0, a, 4'b0000, 1'b1, 32'h0, waited);
		assert (waited == 0) else begin
			$display("Re-read of a just filled line was not ready at once");
			test_errors++;
		end
		check_word("rdata[0]", first, rdata[0]);
		finish_test("read_miss_hit");

		random_traffic(0, 80, 2);
		finish_test("byte_enables");

		// Three tags in one set with dirty lines force writebacks
		wb_before = wb_count;
		for (int t = 0; t < 3; t++) begin
			evict[t] = {16'((1 << 14) + 8 + t), 4'd5, 2'(t)};
			access(1, evict[t], 4'b1111, 1'b0, next_rand(), waited);
		end
		for (int t = 0; t < 3; t++)
			access(1, evict[t], 4'b0101, 1'b0, next_rand(), waited);
		for (int t = 0; t < 3; t++)
			access(1, evict[t], 4'b0000, 1'b1, 32'h0, waited);
		assert (wb_count > wb_before) else begin
			$display("No writeback was seen while evicting dirty lines");
			test_errors++;
		end
		finish_test("eviction_writeback");

		// Both ports contend for the channel
		fork
			random_traffic(0, 1000, 3);
			random_traffic(1, 1000, 3);
		join
		finish_test("shared_channel");

		// Monitor errors of the last edge
		#1;
		errors += test_errors;
		$display("%0d tests, %0d failed, %0d errors, %0d writeback words",
			tests_run, tests_failed, errors, wb_count);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- tb.f
+incdir+design
design/qpimem_pkg.sv
design/qpimem_cache.sv
design/qpimem_arbiter.sv
design/qpimem_subsys.sv
sim/qpi_mem_model.sv
sim/tb_qpimem.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and judge by the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_qpimem -o sim_tb \
	&& out=$(./obj_dir/sim_tb) \
	; echo "$out" \
	&& echo "$out" | grep -q "All tests passed!" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
